// File: arp_tx_defs.svh
// *********************************************************************
// ARP and Ethernet protocol constants for the ARP transmit engine
// include in any file that builds or checks ARP frames
// *********************************************************************

`ifndef ARP_TX_DEFS_SVH
`define ARP_TX_DEFS_SVH

// ethernet
`define ETHERTYPE_ARP    16'h0806
`define BCAST_MAC        48'hffff_ffff_ffff

// arp header fields for ethernet / ipv4
`define ARP_HTYPE_ETH    16'h0001
`define ARP_PTYPE_IPV4   16'h0800
`define ARP_HLEN         8'd6
`define ARP_PLEN         8'd4
`define ARP_OPER_REQUEST 16'h0001
`define ARP_OPER_REPLY   16'h0002

`endif

// File: arp_tx_pkg.sv
// *********************************************************************
// Types shared by the ARP transmit engine
// queries, received packet fields, full frames and the ethernet header
// *********************************************************************

package arp_tx_pkg;

    typedef struct packed {
        logic [31:0] tpa;
    } arp_query_t;

    // fields of a received arp packet
    typedef struct packed {
        logic [15:0] oper;
        logic [47:0] sha;
        logic [31:0] spa;
        logic [47:0] tha;
        logic [31:0] tpa;
    } arp_rx_pkt_t;

    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
        logic [15:0] htype;
        logic [15:0] ptype;
        logic [7:0]  hlen;
        logic [7:0]  plen;
        logic [15:0] oper;
        logic [47:0] sha;
        logic [31:0] spa;
        logic [47:0] tha;
        logic [31:0] tpa;
    } arp_frame_t;

    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

endpackage

// File: arp_request_gen.sv
// *********************************************************************
// ARP request builder
// turns a target ipv4 query into a broadcast request frame held in a
// one-entry output register until the arbiter takes it
// *********************************************************************

`include "arp_tx_defs.svh"

module arp_request_gen (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [47:0]            local_mac,
    input  logic [31:0]            local_ip,
    input  logic                   query_valid,
    output logic                   query_ready,
    input  arp_tx_pkg::arp_query_t query,
    output logic                   frame_valid,
    input  logic                   frame_ready,
    output arp_tx_pkg::arp_frame_t frame
);
    import arp_tx_pkg::*;

    arp_frame_t req_frame;
    logic       query_fire;

    // free when empty or being emptied this cycle
    assign query_ready = !frame_valid || frame_ready;
    assign query_fire  = query_valid && query_ready;

    always_comb begin
        req_frame.dest_mac = `BCAST_MAC;
        req_frame.src_mac  = local_mac;
        req_frame.eth_type = `ETHERTYPE_ARP;
        req_frame.htype    = `ARP_HTYPE_ETH;
        req_frame.ptype    = `ARP_PTYPE_IPV4;
        req_frame.hlen     = `ARP_HLEN;
        req_frame.plen     = `ARP_PLEN;
        req_frame.oper     = `ARP_OPER_REQUEST;
        req_frame.sha      = local_mac;
        req_frame.spa      = local_ip;
        // target mac unknown, that is what we are asking for
        req_frame.tha      = 48'h0;
        req_frame.tpa      = query.tpa;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frame_valid <= 1'b0;
        end else if (query_fire) begin
            frame_valid <= 1'b1;
        end else if (frame_ready) begin
            frame_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (query_fire) begin
            frame <= req_frame;
        end
    end

endmodule

// File: arp_reply_gen.sv
// *********************************************************************
// ARP reply builder
// accepts received arp packet fields, keeps requests for local_ip and
// builds a unicast reply; everything else is accepted and dropped
// *********************************************************************

`include "arp_tx_defs.svh"

module arp_reply_gen (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [47:0]             local_mac,
    input  logic [31:0]             local_ip,
    input  logic                    rx_valid,
    output logic                    rx_ready,
    input  arp_tx_pkg::arp_rx_pkt_t rx_pkt,
    output logic                    frame_valid,
    input  logic                    frame_ready,
    output arp_tx_pkg::arp_frame_t  frame
);
    import arp_tx_pkg::*;

    arp_frame_t rep_frame;
    logic       rx_fire;
    logic       rx_hit;

    assign rx_ready = !frame_valid || frame_ready;
    assign rx_fire  = rx_valid && rx_ready;

    // only requests aimed at us get an answer
    assign rx_hit = (rx_pkt.oper == `ARP_OPER_REQUEST) && (rx_pkt.tpa == local_ip);

    always_comb begin
        rep_frame.dest_mac = rx_pkt.sha;
        rep_frame.src_mac  = local_mac;
        rep_frame.eth_type = `ETHERTYPE_ARP;
        rep_frame.htype    = `ARP_HTYPE_ETH;
        rep_frame.ptype    = `ARP_PTYPE_IPV4;
        rep_frame.hlen     = `ARP_HLEN;
        rep_frame.plen     = `ARP_PLEN;
        rep_frame.oper     = `ARP_OPER_REPLY;
        rep_frame.sha      = local_mac;
        rep_frame.spa      = local_ip;
        rep_frame.tha      = rx_pkt.sha;
        rep_frame.tpa      = rx_pkt.spa;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frame_valid <= 1'b0;
        end else if (rx_fire && rx_hit) begin
            frame_valid <= 1'b1;
        end else if (frame_ready) begin
            // also covers a dropped packet arriving as the reply leaves
            frame_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_fire && rx_hit) begin
            frame <= rep_frame;
        end
    end

endmodule

// File: arp_frame_arb.sv
// *********************************************************************
// Round-robin merge of request and reply frames
// the winner is copied into a one-entry holding register so a frame
// can wait there while the serializer is still busy
// *********************************************************************

module arp_frame_arb (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  arp_tx_pkg::arp_frame_t req_frame,
    input  logic                   rep_valid,
    output logic                   rep_ready,
    input  arp_tx_pkg::arp_frame_t rep_frame,
    output logic                   out_valid,
    input  logic                   out_ready,
    output arp_tx_pkg::arp_frame_t out_frame
);
    import arp_tx_pkg::*;

    arp_frame_t sel_frame;
    logic       hold_free;
    logic       sel_req;
    logic       sel_rep;
    logic       grant;
    logic       last_rep;

    assign hold_free = !out_valid || out_ready;

    // on contention the side that lost last time wins
    assign sel_req = req_valid && (!rep_valid || last_rep);
    assign sel_rep = rep_valid && !sel_req;

    assign grant     = hold_free && (sel_req || sel_rep);
    assign req_ready = hold_free && sel_req;
    assign rep_ready = hold_free && sel_rep;
    assign sel_frame = sel_req ? req_frame : rep_frame;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            // requests get the first turn
            last_rep  <= 1'b1;
        end else if (grant) begin
            out_valid <= 1'b1;
            last_rep  <= sel_rep;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            out_frame <= sel_frame;
        end
    end

endmodule

// File: arp_eth_tx.sv
// *********************************************************************
// ARP frame serializer for a 64-bit ethernet datapath
// takes one frame, presents the ethernet header on its own handshake
// and streams the 28-byte arp body as four payload words
// *********************************************************************

module arp_eth_tx (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   frame_valid,
    output logic                   frame_ready,
    input  arp_tx_pkg::arp_frame_t frame,
    output logic                   eth_hdr_valid,
    input  logic                   eth_hdr_ready,
    output arp_tx_pkg::eth_hdr_t   eth_hdr,
    output logic [63:0]            payload_tdata,
    output logic [7:0]             payload_tkeep,
    output logic                   payload_tvalid,
    input  logic                   payload_tready,
    output logic                   payload_tlast,
    output logic                   busy
);
    import arp_tx_pkg::*;

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_WRITE = 2'd1;
    localparam logic [1:0] ST_LAST  = 2'd2;

    logic [1:0] state_reg;
    logic [1:0] state_next;
    logic [1:0] ptr_reg;
    logic [1:0] ptr_next;
    logic       store_frame;
    logic       load_word;
    logic       hdr_valid_next;
    logic       busy_next;
    arp_frame_t frame_reg;
    arp_frame_t word_src;

    // big-endian field order, then byte 0 moved to tdata[7:0]
    function automatic logic [63:0] payload_word(arp_frame_t f, logic [1:0] idx);
        logic [63:0] be;
        logic [63:0] le;
        case (idx)
            2'd0:    be = {f.htype, f.ptype, f.hlen, f.plen, f.oper};
            2'd1:    be = {f.sha, f.spa[31:16]};
            2'd2:    be = {f.spa[15:0], f.tha};
            default: be = {f.tpa, 32'h0};
        endcase
        for (int i = 0; i < 8; i++) begin
            le[8*i +: 8] = be[63-8*i -: 8];
        end
        return le;
    endfunction

    assign eth_hdr.dest_mac = frame_reg.dest_mac;
    assign eth_hdr.src_mac  = frame_reg.src_mac;
    assign eth_hdr.eth_type = frame_reg.eth_type;

    // word 0 comes straight from the input on acceptance
    assign word_src = store_frame ? frame : frame_reg;

    always_comb begin
        state_next     = state_reg;
        ptr_next       = ptr_reg;
        store_frame    = 1'b0;
        load_word      = 1'b0;
        hdr_valid_next = eth_hdr_valid && !eth_hdr_ready;
        case (state_reg)
            ST_IDLE: begin
                if (frame_valid && frame_ready) begin
                    store_frame    = 1'b1;
                    load_word      = 1'b1;
                    hdr_valid_next = 1'b1;
                    state_next     = ST_WRITE;
                end
            end
            ST_WRITE: begin
                if (payload_tready) begin
                    load_word = 1'b1;
                    if (ptr_reg == 2'd3) begin
                        state_next = ST_LAST;
                    end
                end
            end
            ST_LAST: begin
                // word 3 sits in the output register
                if (payload_tready) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
        // pointer wraps to 0 after word 3 is loaded
        if (load_word) begin
            ptr_next = ptr_reg + 2'd1;
        end
        busy_next = (state_next != ST_IDLE) || hdr_valid_next;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_reg      <= ST_IDLE;
            ptr_reg        <= 2'd0;
            frame_ready    <= 1'b0;
            eth_hdr_valid  <= 1'b0;
            payload_tvalid <= 1'b0;
            payload_tkeep  <= 8'h00;
            payload_tlast  <= 1'b0;
            busy           <= 1'b0;
        end else begin
            state_reg      <= state_next;
            ptr_reg        <= ptr_next;
            eth_hdr_valid  <= hdr_valid_next;
            payload_tvalid <= state_next != ST_IDLE;
            busy           <= busy_next;
            frame_ready    <= !busy_next;
            if (load_word) begin
                payload_tkeep <= (ptr_reg == 2'd3) ? 8'h0f : 8'hff;
                payload_tlast <= ptr_reg == 2'd3;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store_frame) begin
            frame_reg <= frame;
        end
        if (load_word) begin
            payload_tdata <= payload_word(word_src, ptr_reg);
        end
    end

endmodule

// File: arp_tx_top.sv
// *********************************************************************
// ARP transmit engine top level
// request and reply builders feed a round-robin arbiter, whose output
// is serialized into an ethernet header and a 64-bit payload stream
// *********************************************************************

module arp_tx_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [47:0]             local_mac,
    input  logic [31:0]             local_ip,
    input  logic                    query_valid,
    output logic                    query_ready,
    input  arp_tx_pkg::arp_query_t  query,
    input  logic                    rx_valid,
    output logic                    rx_ready,
    input  arp_tx_pkg::arp_rx_pkt_t rx_pkt,
    output logic                    eth_hdr_valid,
    input  logic                    eth_hdr_ready,
    output arp_tx_pkg::eth_hdr_t    eth_hdr,
    output logic [63:0]             payload_tdata,
    output logic [7:0]              payload_tkeep,
    output logic                    payload_tvalid,
    input  logic                    payload_tready,
    output logic                    payload_tlast,
    output logic                    busy
);
    import arp_tx_pkg::*;

    arp_frame_t req_frame;
    arp_frame_t rep_frame;
    arp_frame_t frame;
    logic       req_frame_valid;
    logic       req_frame_ready;
    logic       rep_frame_valid;
    logic       rep_frame_ready;
    logic       frame_valid;
    logic       frame_ready;

    arp_request_gen u_request_gen (
        .clk         (clk),
        .rst         (rst),
        .local_mac   (local_mac),
        .local_ip    (local_ip),
        .query_valid (query_valid),
        .query_ready (query_ready),
        .query       (query),
        .frame_valid (req_frame_valid),
        .frame_ready (req_frame_ready),
        .frame       (req_frame)
    );

    arp_reply_gen u_reply_gen (
        .clk         (clk),
        .rst         (rst),
        .local_mac   (local_mac),
        .local_ip    (local_ip),
        .rx_valid    (rx_valid),
        .rx_ready    (rx_ready),
        .rx_pkt      (rx_pkt),
        .frame_valid (rep_frame_valid),
        .frame_ready (rep_frame_ready),
        .frame       (rep_frame)
    );

    arp_frame_arb u_frame_arb (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_frame_valid),
        .req_ready (req_frame_ready),
        .req_frame (req_frame),
        .rep_valid (rep_frame_valid),
        .rep_ready (rep_frame_ready),
        .rep_frame (rep_frame),
        .out_valid (frame_valid),
        .out_ready (frame_ready),
        .out_frame (frame)
    );

    arp_eth_tx u_eth_tx (
        .clk            (clk),
        .rst            (rst),
        .frame_valid    (frame_valid),
        .frame_ready    (frame_ready),
        .frame          (frame),
        .eth_hdr_valid  (eth_hdr_valid),
        .eth_hdr_ready  (eth_hdr_ready),
        .eth_hdr        (eth_hdr),
        .payload_tdata  (payload_tdata),
        .payload_tkeep  (payload_tkeep),
        .payload_tvalid (payload_tvalid),
        .payload_tready (payload_tready),
        .payload_tlast  (payload_tlast),
        .busy           (busy)
    );

endmodule

// File: arp_tx_assert.sv
// *********************************************************************
// Protocol assertions for the ARP frame serializer
// bound into every arp_eth_tx instance, reports through $error only
// *********************************************************************

module arp_tx_assert (
    input logic        clk,
    input logic        rst,
    input logic        eth_hdr_valid,
    input logic        payload_tvalid,
    input logic        payload_tready,
    input logic [63:0] payload_tdata,
    input logic [7:0]  payload_tkeep,
    input logic        payload_tlast,
    input logic        frame_ready,
    input logic        busy
);
    timeunit 1ns;
    timeprecision 1ps;

    // a stalled word must not change
    assert property (@(posedge clk) disable iff (rst)
        payload_tvalid && !payload_tready |=>
            payload_tvalid && $stable(payload_tdata) && $stable(payload_tkeep)
            && $stable(payload_tlast))
        else $error("payload word changed while stalled");

    assert property (@(posedge clk) disable iff (rst)
        payload_tvalid && payload_tlast |-> payload_tkeep == 8'h0f)
        else $error("tlast on a word whose tkeep is not 0x0f");

    // header or payload still pending means busy and no new frame taken
    assert property (@(posedge clk) disable iff (rst)
        eth_hdr_valid || payload_tvalid |-> busy && !frame_ready)
        else $error("frame_ready high or busy low while a frame is in flight");

endmodule

bind arp_eth_tx arp_tx_assert u_protocol_assert (
    .clk            (clk),
    .rst            (rst),
    .eth_hdr_valid  (eth_hdr_valid),
    .payload_tvalid (payload_tvalid),
    .payload_tready (payload_tready),
    .payload_tdata  (payload_tdata),
    .payload_tkeep  (payload_tkeep),
    .payload_tlast  (payload_tlast),
    .frame_ready    (frame_ready),
    .busy           (busy)
);

// File: tb_arp_tx.sv
// *********************************************************************
// Self-checking testbench for the ARP transmit engine
// drives queries and received packets from a seeded xorshift source,
// rebuilds each output frame from header and payload and checks it
// against a reference model, with random back-pressure on the outputs
// *********************************************************************

`include "arp_tx_defs.svh"

module tb_arp_tx;
    timeunit 1ns;
    timeprecision 1ps;

    import arp_tx_pkg::*;

    localparam int CLK_HALF     = 20;
    localparam int DRIVE_DELAY  = 5;
    localparam int STREAM_LEN   = 40;
    localparam int TXN_COUNT    = 4 + 4 * STREAM_LEN;
    localparam int TXN_CYCLES   = 40;
    localparam int QUIET_CYCLES = 20;
    localparam int TIMEOUT_NS   = (TXN_COUNT * TXN_CYCLES + 200) * 2 * CLK_HALF;

    logic        clk;
    logic        rst;
    logic [47:0] local_mac;
    logic [31:0] local_ip;
    logic        query_valid;
    logic        query_ready;
    arp_query_t  query;
    logic        rx_valid;
    logic        rx_ready;
    arp_rx_pkt_t rx_pkt;
    logic        eth_hdr_valid;
    logic        eth_hdr_ready;
    eth_hdr_t    eth_hdr;
    logic [63:0] payload_tdata;
    logic [7:0]  payload_tkeep;
    logic        payload_tvalid;
    logic        payload_tready;
    logic        payload_tlast;
    logic        busy;

    logic [31:0]      rng_state = 32'd97;
    logic             random_ready;
    string            test_name;
    arp_frame_t       req_q[$];
    arp_frame_t       rep_q[$];
    eth_hdr_t         hdr_q[$];
    logic [255:0]     body_q[$];
    logic [3:0][63:0] word_buf;
    logic [1:0]       word_idx;

    arp_tx_top DUT (
        .clk            (clk),
        .rst            (rst),
        .local_mac      (local_mac),
        .local_ip       (local_ip),
        .query_valid    (query_valid),
        .query_ready    (query_ready),
        .query          (query),
        .rx_valid       (rx_valid),
        .rx_ready       (rx_ready),
        .rx_pkt         (rx_pkt),
        .eth_hdr_valid  (eth_hdr_valid),
        .eth_hdr_ready  (eth_hdr_ready),
        .eth_hdr        (eth_hdr),
        .payload_tdata  (payload_tdata),
        .payload_tkeep  (payload_tkeep),
        .payload_tvalid (payload_tvalid),
        .payload_tready (payload_tready),
        .payload_tlast  (payload_tlast),
        .busy           (busy)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // byte 0 of the wire sits in bits 7:0, turn it into msb-first order
    function automatic logic [63:0] wire_to_be(logic [63:0] w);
        logic [63:0] be;
        for (int i = 0; i < 8; i++) begin
            be[63-8*i -: 8] = w[8*i +: 8];
        end
        return be;
    endfunction

    function automatic arp_frame_t expected_request(logic [31:0] tpa);
        arp_frame_t f;
        f.dest_mac = `BCAST_MAC;
        f.src_mac  = local_mac;
        f.eth_type = `ETHERTYPE_ARP;
        f.htype    = `ARP_HTYPE_ETH;
        f.ptype    = `ARP_PTYPE_IPV4;
        f.hlen     = `ARP_HLEN;
        f.plen     = `ARP_PLEN;
        f.oper     = `ARP_OPER_REQUEST;
        f.sha      = local_mac;
        f.spa      = local_ip;
        f.tha      = 48'h0;
        f.tpa      = tpa;
        return f;
    endfunction

    function automatic arp_frame_t expected_reply(arp_rx_pkt_t pkt);
        arp_frame_t f;
        f          = expected_request(pkt.spa);
        f.dest_mac = pkt.sha;
        f.oper     = `ARP_OPER_REPLY;
        f.tha      = pkt.sha;
        return f;
    endfunction

    function automatic arp_frame_t frame_from_stream(eth_hdr_t h, logic [255:0] body);
        arp_frame_t  f;
        logic [63:0] w0;
        logic [63:0] w1;
        logic [63:0] w2;
        logic [63:0] w3;
        w0 = wire_to_be(body[63:0]);
        w1 = wire_to_be(body[127:64]);
        w2 = wire_to_be(body[191:128]);
        w3 = wire_to_be(body[255:192]);
        f.dest_mac = h.dest_mac;
        f.src_mac  = h.src_mac;
        f.eth_type = h.eth_type;
        f.htype    = w0[63:48];
        f.ptype    = w0[47:32];
        f.hlen     = w0[31:24];
        f.plen     = w0[23:16];
        f.oper     = w0[15:0];
        f.sha      = w1[63:16];
        f.spa      = {w1[15:0], w2[63:48]};
        f.tha      = w2[47:0];
        f.tpa      = w3[63:32];
        return f;
    endfunction

    task automatic compare_value(string name, logic [447:0] expected, logic [447:0] actual);
        if (actual !== expected) begin
            $display("** Error [%s] expected %0h actual %0h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic score_frame(arp_frame_t act);
        logic is_reply;
        is_reply = act.oper == `ARP_OPER_REPLY;
        if ((is_reply && rep_q.size() == 0) || (!is_reply && req_q.size() == 0)) begin
            $display("%s: a frame came out that no query or matching request asked for",
                     test_name);
            $display("TEST FAILED");
            $fatal(1, "unexpected frame");
        end else if (is_reply) begin
            compare_value({test_name, " reply frame"}, rep_q.pop_front(), act);
        end else begin
            compare_value({test_name, " request frame"}, req_q.pop_front(), act);
        end
    endtask

    task automatic idle_cycles(int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic send_query(logic [31:0] tpa);
        logic accepted;
        query.tpa   = tpa;
        query_valid = 1'b1;
        accepted    = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = query_ready;
            if (accepted) begin
                req_q.push_back(expected_request(tpa));
            end
            @(posedge clk);
            #DRIVE_DELAY;
        end
        query_valid = 1'b0;
    endtask

    task automatic send_rx(arp_rx_pkt_t pkt);
        logic accepted;
        rx_pkt   = pkt;
        rx_valid = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = rx_ready;
            // only a request for our own address earns a reply
            if (accepted && pkt.oper == `ARP_OPER_REQUEST && pkt.tpa == local_ip) begin
                rep_q.push_back(expected_reply(pkt));
            end
            @(posedge clk);
            #DRIVE_DELAY;
        end
        rx_valid = 1'b0;
    endtask

    task automatic query_stream(int count);
        logic [31:0] r;
        for (int n = 0; n < count; n++) begin
            r = next_rand();
            send_query(r);
            idle_cycles(int'(r[9:8]));
        end
    endtask

    task automatic rx_stream(int count);
        arp_rx_pkt_t pkt;
        logic [31:0] r;
        logic [31:0] s;
        for (int n = 0; n < count; n++) begin
            r = next_rand();
            s = next_rand();
            pkt.oper = (s[1:0] == 2'd0) ? `ARP_OPER_REPLY : `ARP_OPER_REQUEST;
            pkt.sha  = {r, s[31:16]};
            pkt.spa  = next_rand();
            pkt.tha  = 48'h0;
            pkt.tpa  = s[2] ? local_ip : next_rand();
            send_rx(pkt);
            idle_cycles(int'(s[5:4]));
        end
    endtask

    task automatic wait_drained();
        while (req_q.size() != 0 || rep_q.size() != 0) begin
            @(posedge clk);
        end
        // quiet window so a stray frame is still caught
        repeat (QUIET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        // nothing left in flight, so the serializer must be idle
        compare_value({test_name, " busy after drain"}, 448'(0), 448'(busy));
    endtask

    // output ready, always high or random
    initial begin
        logic [31:0] r;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (random_ready) begin
                r = next_rand();
                eth_hdr_ready  = r[0] | r[1];
                payload_tready = r[2] | r[3];
            end else begin
                eth_hdr_ready  = 1'b1;
                payload_tready = 1'b1;
            end
        end
    end

    // handshakes sampled at the falling edge, before the edge that transfers
    always @(negedge clk) begin
        arp_frame_t   act;
        logic [255:0] body;
        eth_hdr_t     hdr;
        if (!rst) begin
            // a frame in flight keeps the serializer busy
            if (eth_hdr_valid || payload_tvalid) begin
                compare_value({test_name, " busy"}, 448'(1), 448'(busy));
            end
            if (eth_hdr_valid && eth_hdr_ready) begin
                hdr_q.push_back(eth_hdr);
            end
            if (payload_tvalid && payload_tready) begin
                compare_value($sformatf("%s tkeep word %0d", test_name, word_idx),
                              448'((word_idx == 2'd3) ? 8'h0f : 8'hff), 448'(payload_tkeep));
                compare_value($sformatf("%s tlast word %0d", test_name, word_idx),
                              448'(word_idx == 2'd3), 448'(payload_tlast));
                word_buf[word_idx] = payload_tdata;
                if (word_idx == 2'd3) begin
                    body_q.push_back(word_buf);
                end
                word_idx = word_idx + 2'd1;
            end
            while (hdr_q.size() > 0 && body_q.size() > 0) begin
                hdr  = hdr_q.pop_front();
                body = body_q.pop_front();
                compare_value({test_name, " word 3 padding"}, 448'(0), 448'(body[255:224]));
                act = frame_from_stream(hdr, body);
                score_frame(act);
            end
        end
    end

    initial begin
        #TIMEOUT_NS;
        $display("watchdog: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        arp_rx_pkt_t pkt;
        rst            = 1'b1;
        local_mac      = 48'h02_11_22_33_44_55;
        local_ip       = 32'hc0a8_010a;
        query_valid    = 1'b0;
        query          = '0;
        rx_valid       = 1'b0;
        rx_pkt         = '0;
        eth_hdr_ready  = 1'b0;
        payload_tready = 1'b0;
        random_ready   = 1'b0;
        word_idx       = 2'd0;
        word_buf       = '0;
        test_name      = "reset_idle";
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        // no input yet, so nothing may come out
        repeat (8) begin
            @(negedge clk);
            compare_value(test_name, 448'(0), 448'({eth_hdr_valid, payload_tvalid, busy}));
        end
        @(posedge clk);
        #DRIVE_DELAY;

        test_name = "single_request";
        send_query(32'hc0a8_0142);
        wait_drained();

        test_name = "matching_reply";
        pkt.oper  = `ARP_OPER_REQUEST;
        pkt.sha   = 48'h02_a0_b1_c2_d3_e4;
        pkt.spa   = 32'hc0a8_0177;
        pkt.tha   = 48'h0;
        pkt.tpa   = local_ip;
        send_rx(pkt);
        wait_drained();

        test_name = "filtered_packets";
        pkt.tpa   = local_ip ^ 32'h1;
        send_rx(pkt);
        pkt.tpa   = local_ip;
        pkt.oper  = `ARP_OPER_REPLY;
        send_rx(pkt);
        wait_drained();

        test_name = "mixed_traffic";
        fork
            query_stream(STREAM_LEN);
            rx_stream(STREAM_LEN);
        join
        wait_drained();

        test_name    = "random_backpressure";
        random_ready = 1'b1;
        fork
            query_stream(STREAM_LEN);
            rx_stream(STREAM_LEN);
        join
        wait_drained();

        if (req_q.size() == 0 && rep_q.size() == 0 &&
            hdr_q.size() == 0 && body_q.size() == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("frames or headers were left over at the end of the run");
            $display("TEST FAILED");
            $fatal(1, "leftover data");
        end
    end

endmodule

// File: arp_tx.f
+incdir+.
arp_tx_pkg.sv
arp_request_gen.sv
arp_reply_gen.sv
arp_frame_arb.sv
arp_eth_tx.sv
arp_tx_top.sv
arp_tx_assert.sv
tb_arp_tx.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ARP transmit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f arp_tx.f --top-module tb_arp_tx -o tb_arp_tx_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/tb_arp_tx_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
exit 0
